// ==== common/mag_error_pkg.sv ====
`default_nettype none

package mag_error_pkg;

	localparam int fix_w = 16;	// Q2.14 word
	localparam int frac_w = 14;
	localparam int acc_w = 36;	// sum of several Q4.28 products

	typedef logic signed [fix_w-1:0] fix_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vec3_t;

	typedef struct packed {
		fix_t c11;
		fix_t c12;
		fix_t c13;
		fix_t c21;
		fix_t c22;
		fix_t c23;
		fix_t c31;
		fix_t c32;
		fix_t c33;
	} dcm_t;

	// register file entries, mx..mz already remapped
	typedef enum logic [4:0] {
		sel_mx, sel_my, sel_mz,
		sel_c11, sel_c12, sel_c13,
		sel_c21, sel_c22, sel_c23,
		sel_c31, sel_c32, sel_c33,
		sel_hx, sel_hy, sel_bz, sel_bx,
		sel_wx, sel_wy, sel_wz,
		sel_ex, sel_ey, sel_ez
	} reg_sel_t;

	localparam int reg_cnt = 22;

	typedef struct packed {
		reg_sel_t op_a;
		reg_sel_t op_b;
		logic neg;	// subtract product
		logic last;	// close the sum into dst
		logic root;	// sqrt of the running sum into dst
		reg_sel_t dst;
	} step_t;

	typedef struct packed {
		logic valid;
		reg_sel_t dst;
		fix_t value;
	} wb_t;

	localparam int prog_len = 24;
	localparam int step_idx_w = $clog2(prog_len);

	////////////////////////////////////////////////////////////////////////////
	// step program: op_a, op_b, neg, last, root, dst
	////////////////////////////////////////////////////////////////////////////
	localparam step_t step_prog [prog_len] = '{
		'{sel_mx, sel_c11, 1'b0, 1'b0, 1'b0, sel_hx},	// h = C' m
		'{sel_my, sel_c21, 1'b0, 1'b0, 1'b0, sel_hx},
		'{sel_mz, sel_c31, 1'b0, 1'b1, 1'b0, sel_hx},
		'{sel_mx, sel_c12, 1'b0, 1'b0, 1'b0, sel_hy},
		'{sel_my, sel_c22, 1'b0, 1'b0, 1'b0, sel_hy},
		'{sel_mz, sel_c32, 1'b0, 1'b1, 1'b0, sel_hy},
		'{sel_mx, sel_c13, 1'b0, 1'b0, 1'b0, sel_bz},
		'{sel_my, sel_c23, 1'b0, 1'b0, 1'b0, sel_bz},
		'{sel_mz, sel_c33, 1'b0, 1'b1, 1'b0, sel_bz},
		'{sel_hx, sel_hx, 1'b0, 1'b0, 1'b0, sel_bx},	// hx^2 + hy^2
		'{sel_hy, sel_hy, 1'b0, 1'b0, 1'b0, sel_bx},
		'{sel_hx, sel_hy, 1'b0, 1'b0, 1'b1, sel_bx},	// operands unused
		'{sel_bx, sel_c11, 1'b0, 1'b0, 1'b0, sel_wx},	// w = C b
		'{sel_bz, sel_c13, 1'b0, 1'b1, 1'b0, sel_wx},
		'{sel_bx, sel_c21, 1'b0, 1'b0, 1'b0, sel_wy},
		'{sel_bz, sel_c23, 1'b0, 1'b1, 1'b0, sel_wy},
		'{sel_bx, sel_c31, 1'b0, 1'b0, 1'b0, sel_wz},
		'{sel_bz, sel_c33, 1'b0, 1'b1, 1'b0, sel_wz},
		'{sel_mx, sel_wy, 1'b0, 1'b0, 1'b0, sel_ez},	// e = m x w
		'{sel_my, sel_wx, 1'b1, 1'b1, 1'b0, sel_ez},
		'{sel_my, sel_wz, 1'b0, 1'b0, 1'b0, sel_ex},
		'{sel_mz, sel_wy, 1'b1, 1'b1, 1'b0, sel_ex},
		'{sel_mz, sel_wx, 1'b0, 1'b0, 1'b0, sel_ey},
		'{sel_mx, sel_wz, 1'b1, 1'b1, 1'b0, sel_ey}
	};

endpackage

`default_nettype wire

// ==== execute/isqrt_unit.sv ====
`default_nettype none

module isqrt_unit
	import mag_error_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic go,
	input wire logic [2*fix_w-1:0] radicand,
	output fix_t root,
	output logic fin
);

	logic busy;
	logic [$clog2(fix_w)-1:0] cnt;	// iterations left
	logic [fix_w-1:0] rem;
	logic [2*fix_w-1:0] rad;

	logic [fix_w-1:0] src_rem;
	fix_t src_root;
	logic [2*fix_w-1:0] src_rad;
	logic [fix_w+1:0] rem_sh;
	logic [fix_w+1:0] trial;
	logic [fix_w+1:0] diff;
	logic take;

	// one restoring step, go starts from a clean state
	always_comb begin
		src_rem = go ? '0 : rem;
		src_root = go ? '0 : root;
		src_rad = go ? radicand : rad;
		rem_sh = {src_rem, src_rad[2*fix_w-1 -: 2]};
		trial = {src_root, 2'b01};
		diff = rem_sh - trial;
		take = rem_sh >= trial;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			cnt <= '0;
			fin <= 1'b0;
		end else begin
			fin <= 1'b0;
			if (go) begin
				busy <= 1'b1;
				cnt <= ($clog2(fix_w))'(fix_w - 1);	// first step done on go
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				if (cnt == 1) begin
					busy <= 1'b0;
					fin <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (go || busy) begin
			rem <= take ? diff[fix_w-1:0] : rem_sh[fix_w-1:0];
			root <= {src_root[fix_w-2:0], take};
			rad <= {src_rad[2*fix_w-3:0], 2'b00};
		end
	end

endmodule

`default_nettype wire

// ==== execute/exec_unit.sv ====
`default_nettype none

module exec_unit
	import mag_error_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic issue,
	input wire step_t step,
	output logic ready,
	output reg_sel_t rd_a,
	output reg_sel_t rd_b,
	input wire fix_t val_a,
	input wire fix_t val_b,
	output wb_t wb
);

	// stage 1: operands
	logic s1_valid;
	logic s1_neg;
	logic s1_last;
	logic s1_root;
	reg_sel_t s1_dst;
	fix_t s1_a;
	fix_t s1_b;
	logic signed [2*fix_w-1:0] prod;

	// stage 2: product
	logic s2_valid;
	logic s2_neg;
	logic s2_last;
	reg_sel_t s2_dst;
	logic signed [2*fix_w-1:0] s2_prod;

	logic signed [acc_w-1:0] acc;
	logic signed [acc_w-1:0] acc_nxt;
	logic signed [acc_w-1:0] prod_ext;
	logic signed [acc_w-1:0] acc_shr;

	reg_sel_t root_dst;
	logic sq_go;
	logic sq_fin;
	fix_t sq_root;

	assign rd_a = step.op_a;
	assign rd_b = step.op_b;

	assign prod = s1_a * s1_b;	// full 32 bit product
	assign prod_ext = acc_w'(s2_prod);

	always_comb begin
		acc_nxt = acc;
		if (s2_valid) begin
			acc_nxt = s2_neg ? acc - prod_ext : acc + prod_ext;
		end
	end

	assign acc_shr = acc_nxt >>> frac_w;	// back to Q2.14

	// acc_nxt already holds every product issued before the root step
	assign sq_go = s1_valid && s1_root;

	////////////////////////////////////////////////////////////////////////////
	// pipeline
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			acc <= '0;
			ready <= 1'b1;
		end else begin
			s1_valid <= issue;
			s2_valid <= s1_valid && !s1_root;
			acc <= (sq_go || (s2_valid && s2_last)) ? '0 : acc_nxt;
			if (issue && (step.last || step.root)) begin
				ready <= 1'b0;	// hold decode until write-back
			end else if (wb.valid) begin
				ready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		s1_neg <= step.neg;
		s1_last <= step.last;
		s1_root <= step.root;
		s1_dst <= step.dst;
		s1_a <= val_a;
		s1_b <= val_b;
		s2_neg <= s1_neg;
		s2_last <= s1_last;
		s2_dst <= s1_dst;
		s2_prod <= prod;
		if (sq_go) begin
			root_dst <= s1_dst;
		end
	end

	isqrt_unit i_isqrt_unit (
		.clk      (clk),
		.rst      (rst),
		.go       (sq_go),
		.radicand (acc_nxt[2*fix_w-1:0]),
		.root     (sq_root),
		.fin      (sq_fin)
	);

	// one source at a time, ready keeps them apart
	always_comb begin
		wb.valid = (s2_valid && s2_last) || sq_fin;
		wb.dst = sq_fin ? root_dst : s2_dst;
		wb.value = sq_fin ? sq_root : acc_shr[fix_w-1:0];
	end

endmodule

`default_nettype wire

// ==== design/step_decode.sv ====
`default_nettype none

module step_decode
	import mag_error_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic ready,
	output logic issue,
	output step_t step,
	output logic load,
	output logic publish,
	output logic done
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_drain
	} state_t;

	state_t state;
	logic [step_idx_w-1:0] cnt;	// index of next step
	logic last_issue;

	////////////////////////////////////////////////////////////////////////////
	// outputs decoded from state
	////////////////////////////////////////////////////////////////////////////

	assign load = (state == st_idle) && start;	// capture inputs
	assign issue = (state == st_run) && ready;
	assign step = step_prog[cnt];

	// final write-back has landed once ready returns
	assign publish = (state == st_drain) && ready;

	assign last_issue = issue && (cnt == step_idx_w'(prog_len - 1));

	////////////////////////////////////////////////////////////////////////////
	// sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_run;
						cnt <= '0;
						done <= 1'b0;	// drops the cycle after accept
					end
				end

				st_run: begin
					if (last_issue) begin
						state <= st_drain;
					end else if (issue) begin
						cnt <= cnt + 1'b1;
					end
				end

				st_drain: begin
					if (publish) begin
						state <= st_idle;
						done <= 1'b1;	// same edge as err update
					end
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/result_regs.sv ====
`default_nettype none

module result_regs
	import mag_error_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic load,
	input wire vec3_t mag,
	input wire dcm_t dcm,
	input wire reg_sel_t rd_a,
	input wire reg_sel_t rd_b,
	output fix_t val_a,
	output fix_t val_b,
	input wire wb_t wb,
	input wire logic publish,
	output vec3_t err
);

	fix_t rf [reg_cnt];

	////////////////////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (load) begin
			rf[sel_mx] <= mag.y;	// sensor axes to body axes
			rf[sel_my] <= -mag.x;
			rf[sel_mz] <= mag.z;
			rf[sel_c11] <= dcm.c11;
			rf[sel_c12] <= dcm.c12;
			rf[sel_c13] <= dcm.c13;
			rf[sel_c21] <= dcm.c21;
			rf[sel_c22] <= dcm.c22;
			rf[sel_c23] <= dcm.c23;
			rf[sel_c31] <= dcm.c31;
			rf[sel_c32] <= dcm.c32;
			rf[sel_c33] <= dcm.c33;
		end else if (wb.valid) begin
			rf[wb.dst] <= wb.value;
		end
	end

	// read ports
	assign val_a = rf[rd_a];
	assign val_b = rf[rd_b];

	////////////////////////////////////////////////////////////////////////////
	// published error
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			err <= '0;
		end else if (publish) begin
			err.x <= rf[sel_ex];
			err.y <= rf[sel_ey];
			err.z <= rf[sel_ez];
		end
	end

endmodule

`default_nettype wire

// ==== design/mag_error_top.sv ====
`default_nettype none

module mag_error_top
	import mag_error_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire vec3_t mag,
	input wire dcm_t dcm,
	output vec3_t err,
	output logic done
);

	logic issue;
	step_t step;
	logic ready;
	reg_sel_t rd_a;
	reg_sel_t rd_b;
	fix_t val_a;
	fix_t val_b;
	wb_t wb;
	logic load;
	logic publish;

	step_decode i_step_decode (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.ready   (ready),
		.issue   (issue),
		.step    (step),
		.load    (load),
		.publish (publish),
		.done    (done)
	);

	exec_unit i_exec_unit (
		.clk   (clk),
		.rst   (rst),
		.issue (issue),
		.step  (step),
		.ready (ready),
		.rd_a  (rd_a),
		.rd_b  (rd_b),
		.val_a (val_a),
		.val_b (val_b),
		.wb    (wb)
	);

	result_regs i_result_regs (
		.clk     (clk),
		.rst     (rst),
		.load    (load),
		.mag     (mag),
		.dcm     (dcm),
		.rd_a    (rd_a),
		.rd_b    (rd_b),
		.val_a   (val_a),
		.val_b   (val_b),
		.wb      (wb),
		.publish (publish),
		.err     (err)
	);

endmodule

`default_nettype wire

// ==== verification/mag_error_props.sv ====
`default_nettype none

module mag_error_props
	import mag_error_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic issue,
	input wire logic ready,
	input wire wb_t wb,
	input wire logic go,
	input wire logic [2*fix_w-1:0] radicand,
	input wire fix_t root,
	input wire logic fin
);

	logic [2*fix_w-1:0] rad_held;	// radicand as seen at go
	logic [2*fix_w-1:0] root_sq;
	int fail_cnt = 0;	// failed assertions so far

	always_ff @(posedge clk) begin
		if (go) begin
			rad_held <= radicand;
		end
	end

	assign root_sq = {{fix_w{1'b0}}, root} * {{fix_w{1'b0}}, root};

	issue_needs_ready: assert property (@(posedge clk) disable iff (!rst) issue |-> ready)
		else begin
			fail_cnt++;
			$error("step issued while ready is low");
		end

	// last and root steps both stall decode until their write-back
	wb_single_cycle: assert property (@(posedge clk) disable iff (!rst) wb.valid |=> !wb.valid)
		else begin
			fail_cnt++;
			$error("write-back valid in two consecutive cycles");
		end

	root_not_above: assert property (@(posedge clk) disable iff (!rst) fin |-> root_sq <= rad_held)
		else begin
			fail_cnt++;
			$error("square root result too large for its radicand");
		end

endmodule

bind exec_unit mag_error_props i_mag_error_props (
	.clk      (clk),
	.rst      (rst),
	.issue    (issue),
	.ready    (ready),
	.wb       (wb),
	.go       (sq_go),
	.radicand (acc_nxt[2*fix_w-1:0]),
	.root     (sq_root),
	.fin      (sq_fin)
);

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
	parameter int period = 40,
	parameter int rst_cycles = 16
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		#(period / 10) rst = 1'b1;	// release away from the edge
	end

endmodule

`default_nettype wire

// ==== verification/tb_mag_error.sv ====
`default_nettype none

module tb_mag_error
	import mag_error_pkg::*;
();

	localparam int clk_period = 40;
	localparam int rst_cycles = 16;
	localparam int drive_delay = 4;
	localparam int n_random = 200;
	localparam int n_runs = n_random + 4;	// directed, busy, hold and restart
	localparam int run_timeout = 200;	// cycles from start to done

	logic clk;
	logic rst;
	logic start;
	vec3_t mag;
	dcm_t dcm;
	vec3_t err;
	logic done;

	logic [15:0] lfsr_state;
	int error_cnt;
	int check_cnt;

	tb_clock_gen #(.period(clk_period), .rst_cycles(rst_cycles)) i_tb_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	mag_error_top i_mag_error_top (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.mag   (mag),
		.dcm   (dcm),
		.err   (err),
		.done  (done)
	);

	////////////////////////////////////////////////////////////////////////////
	// random source
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;	// taps 16,14,13,11
		end
		return n;
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// sign and 13 magnitude bits inside +-0.5
	task automatic draw_fix(output fix_t v);
		logic [15:0] bits;
		draw_bits(14, bits);
		v = bits[13] ? -fix_t'({3'b000, bits[12:0]}) : fix_t'({3'b000, bits[12:0]});
	endtask

	task automatic random_inputs(output vec3_t m, output dcm_t c);
		fix_t v [12];
		int i;
		for (i = 0; i < 12; i++) begin
			draw_fix(v[i]);
		end
		m = {v[0], v[1], v[2]};
		c = {v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]};
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic longint to_fix(input longint v);
		return longint'(fix_t'(v[15:0]));	// low word as signed
	endfunction

	function automatic longint close_sum(input longint acc);
		return to_fix(acc >>> frac_w);
	endfunction

	function automatic longint int_sqrt(input longint v);
		longint r;
		longint t;
		int b;
		r = 0;
		for (b = 15; b >= 0; b--) begin
			t = r | (longint'(1) << b);
			if (t * t <= v) begin
				r = t;
			end
		end
		return r;
	endfunction

	function automatic vec3_t model_err(input vec3_t m, input dcm_t c);
		longint mx, my, mz, hx, hy, bz, bx, wx, wy, wz, ex, ey, ez;
		longint c11, c12, c13, c21, c22, c23, c31, c32, c33;
		vec3_t e;
		mx = longint'(m.y);	// sensor to body axes
		my = to_fix(-longint'(m.x));
		mz = longint'(m.z);
		c11 = longint'(c.c11);
		c12 = longint'(c.c12);
		c13 = longint'(c.c13);
		c21 = longint'(c.c21);
		c22 = longint'(c.c22);
		c23 = longint'(c.c23);
		c31 = longint'(c.c31);
		c32 = longint'(c.c32);
		c33 = longint'(c.c33);
		hx = close_sum(mx * c11 + my * c21 + mz * c31);	// earth frame
		hy = close_sum(mx * c12 + my * c22 + mz * c32);
		bz = close_sum(mx * c13 + my * c23 + mz * c33);
		bx = to_fix(int_sqrt(hx * hx + hy * hy));
		wx = close_sum(bx * c11 + bz * c13);	// back to body frame
		wy = close_sum(bx * c21 + bz * c23);
		wz = close_sum(bx * c31 + bz * c33);
		ez = close_sum(mx * wy - my * wx);
		ex = close_sum(my * wz - mz * wy);
		ey = close_sum(mz * wx - mx * wz);
		e.x = ex[15:0];
		e.y = ey[15:0];
		e.z = ez[15:0];
		return e;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// checks and run control
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_err(input vec3_t exp);
		check_value("err.x", err.x, exp.x);
		check_value("err.y", err.y, exp.y);
		check_value("err.z", err.z, exp.z);
	endtask

	task automatic pulse_start(input vec3_t m, input dcm_t c);
		@(posedge clk);
		#drive_delay;
		mag = m;
		dcm = c;
		start = 1'b1;
		@(posedge clk);
		#drive_delay;
		start = 1'b0;
	endtask

	// optionally checks that err holds while done is low
	task automatic wait_done(input bit hold_check, input vec3_t hold_val);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!done && cycles < run_timeout) begin
			if (hold_check) begin
				check_err(hold_val);
			end
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			error_cnt++;
			$display("done did not rise within %0d cycles of start", run_timeout);
		end
	endtask

	task automatic run_and_check(input vec3_t m, input dcm_t c);
		pulse_start(m, c);
		wait_done(1'b0, '0);
		check_err(model_err(m, c));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		vec3_t m;
		vec3_t m2;
		vec3_t old_err;
		dcm_t c;
		dcm_t c2;
		start = 1'b0;
		mag = '0;
		dcm = '0;
		error_cnt = 0;
		check_cnt = 0;
		lfsr_state = 16'd93;

		@(posedge rst);
		@(negedge clk);
		check_value("done", {15'b0, done}, 16'd0);
		check_err('0);

		m = '0;	// m = (0.5, 0.25, 0) with identity attitude
		m.x = 16'sd8192;
		m.y = 16'sd4096;
		c = '0;
		c.c11 = 16'sd16384;
		c.c22 = 16'sd16384;
		c.c33 = 16'sd16384;
		run_and_check(m, c);

		repeat (n_random) begin
			random_inputs(m, c);
			run_and_check(m, c);
		end

		random_inputs(m, c);	// second start lands mid run
		random_inputs(m2, c2);
		pulse_start(m, c);
		repeat (5) @(posedge clk);
		pulse_start(m2, c2);
		wait_done(1'b0, '0);
		old_err = model_err(m, c);
		check_err(old_err);

		repeat (50) begin
			@(negedge clk);
			check_value("done", {15'b0, done}, 16'd1);
			check_err(old_err);
		end

		random_inputs(m, c);
		pulse_start(m, c);
		check_value("done", {15'b0, done}, 16'd0);
		wait_done(1'b1, old_err);
		check_err(model_err(m, c));

		// failed concurrent assertions count as errors too
		error_cnt += i_mag_error_top.i_exec_unit.i_mag_error_props.fail_cnt;

		$display("%0d checks, %0d errors", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		#((n_runs + 4) * 200 * clk_period);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/mag_error_pkg.sv
execute/isqrt_unit.sv
execute/exec_unit.sv
design/step_decode.sv
design/result_regs.sv
design/mag_error_top.sv
verification/mag_error_props.sv
verification/tb_clock_gen.sv
verification/tb_mag_error.sv

// ==== Makefile ====
# Verilator flow for the magnetometer error unit

VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TB_TOP     ?= tb_mag_error
RTL_TOP    ?= mag_error_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --assert -j 0
PASS_MSG   ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
